/* include/dma_cfg.svh */
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// --------------------
// Region sharing
// --------------------
// Regions sharing the read engine
`define DMA_N_REGIONS 4
// Region index width
`define DMA_N_REGIONS_BITS 2
// Depth of routing and completion queues
`define DMA_N_OUTSTANDING 8

// --------------------
// Field widths
// --------------------
`define DMA_DATA_BITS 32
`define DMA_ADDR_BITS 32
`define DMA_LEN_BITS 12
`define DMA_PID_BITS 6

`endif

/* verilog/dma_pkg.sv */
`include "dma_cfg.svh"

package dma_pkg;

  // Byte offset bits within one memory word
  localparam int BEAT_LOG_BITS = $clog2(`DMA_DATA_BITS / 8);
  // Width of a beat count
  localparam int BLEN_BITS = `DMA_LEN_BITS - BEAT_LOG_BITS;

  // Request as forwarded to the engine
  typedef struct packed {
    logic [`DMA_ADDR_BITS-1:0] addr;
    logic [`DMA_LEN_BITS-1:0]  len;
    logic                      ctl;
    logic [`DMA_PID_BITS-1:0]  pid;
  } dma_req_t;

  // Routing queue entry, beats stored minus one
  typedef struct packed {
    logic                           ctl;
    logic [`DMA_N_REGIONS_BITS-1:0] region;
    logic [BLEN_BITS-1:0]           beats_m1;
  } route_entry_t;

  // Completion queue entry
  typedef struct packed {
    logic [`DMA_N_REGIONS_BITS-1:0] region;
    logic [`DMA_PID_BITS-1:0]       pid;
  } done_entry_t;

endpackage

/* verilog/seq_queue.sv */
`timescale 1ns/1ps

module seq_queue #(
  parameter int  DEPTH   = 8,
  parameter type entry_t = logic [7:0]
) (
  input  logic   aclk,
  input  logic   aresetn,
  input  logic   in_valid,
  output logic   in_ready,
  input  entry_t in_data,
  output logic   out_valid,
  input  logic   out_ready,
  output entry_t out_data
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(DEPTH - 1);

  // Entry storage
  entry_t mem [DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS:0]   count;
  logic                push;
  logic                pop;

  // Full blocks push even if a pop happens in the same cycle
  assign in_ready  = (count != (PTR_BITS+1)'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap at the last slot for any depth
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* verilog/dma_rr_arbiter.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_rr_arbiter import dma_pkg::*; (
  input  logic                          aclk,
  input  logic                          aresetn,

  // Region requests
  input  logic [`DMA_N_REGIONS-1:0]     req_valid,
  output logic [`DMA_N_REGIONS-1:0]     req_ready,
  input  logic [`DMA_ADDR_BITS-1:0]     req_addr [`DMA_N_REGIONS],
  input  logic [`DMA_LEN_BITS-1:0]      req_len [`DMA_N_REGIONS],
  input  logic [`DMA_N_REGIONS-1:0]     req_ctl,
  input  logic [`DMA_PID_BITS-1:0]      req_pid [`DMA_N_REGIONS],

  // Engine side
  output logic                          eng_valid,
  input  logic                          eng_ready,
  output dma_req_t                      eng_req,

  // Routing queue push
  output logic                          route_push_valid,
  input  logic                          route_push_ready,
  output route_entry_t                  route_push_data,

  // Completion queue push
  output logic                          done_push_valid,
  input  logic                          done_push_ready,
  output done_entry_t                   done_push_data
);

  localparam int N  = `DMA_N_REGIONS;
  localparam int RB = `DMA_N_REGIONS_BITS;
  localparam logic [RB-1:0] LAST_REGION = RB'(N - 1);

  logic [RB-1:0]            rr_ptr;
  logic [RB-1:0]            sel;
  logic                     found;
  logic                     room;
  logic                     accept;
  logic [`DMA_LEN_BITS-1:0] len_m1;

  // --------------------
  // Selection
  // --------------------
  // First valid region at or after the pointer
  always_comb begin
    int idx;
    found = 1'b0;
    sel   = rr_ptr;
    for (int i = 0; i < N; i++) begin
      idx = int'(rr_ptr) + i;
      // Wrap past the last region
      if (idx >= N) begin
        idx = idx - N;
      end
      if (!found && req_valid[idx]) begin
        found = 1'b1;
        sel   = idx[RB-1:0];
      end
    end
  end

  // Both queues need a free slot before forwarding
  assign room      = route_push_ready && done_push_ready;
  assign eng_valid = found && room;
  assign accept    = eng_valid && eng_ready;

  // Selected region sees ready in the same cycle as the engine
  always_comb begin
    req_ready      = '0;
    req_ready[sel] = found && room && eng_ready;
  end

  assign eng_req.addr = req_addr[sel];
  assign eng_req.len  = req_len[sel];
  assign eng_req.ctl  = req_ctl[sel];
  assign eng_req.pid  = req_pid[sel];

  // --------------------
  // Queue loading
  // --------------------
  // Beats minus one from the byte length
  assign len_m1 = req_len[sel] - 1'b1;

  assign route_push_valid         = accept;
  assign route_push_data.ctl      = req_ctl[sel];
  assign route_push_data.region   = sel;
  assign route_push_data.beats_m1 = len_m1[`DMA_LEN_BITS-1:BEAT_LOG_BITS];

  // Completion entry only when asked for
  assign done_push_valid       = accept && req_ctl[sel];
  assign done_push_data.region = sel;
  assign done_push_data.pid    = req_pid[sel];

  // --------------------
  // Round-robin pointer
  // --------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr_ptr <= '0;
    end else if (accept) begin
      // Next search starts after the accepted region
      if (sel == LAST_REGION) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= sel + 1'b1;
      end
    end
  end

endmodule

/* verilog/dma_read_engine.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_read_engine import dma_pkg::*; (
  input  logic                         aclk,
  input  logic                         aresetn,

  // Request in
  input  logic                         eng_valid,
  output logic                         eng_ready,
  input  dma_req_t                     eng_req,

  // Beats out
  output logic                         beat_valid,
  input  logic                         beat_ready,
  output logic [`DMA_DATA_BITS-1:0]    beat_data,
  output logic                         beat_last,

  // Wishbone classic master
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic                         wb_we,
  output logic [`DMA_ADDR_BITS-1:0]    wb_adr,
  output logic [`DMA_DATA_BITS/8-1:0]  wb_sel,
  input  logic [`DMA_DATA_BITS-1:0]    wb_dat_i,
  input  logic                         wb_ack
);

  localparam int WORD_BYTES = `DMA_DATA_BITS / 8;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,
    ST_BEAT
  } state_t;

  state_t                    state;
  logic [`DMA_ADDR_BITS-1:0] addr_r;
  logic [BLEN_BITS-1:0]      remaining;
  logic [`DMA_DATA_BITS-1:0] data_r;
  logic                      last_r;
  logic [`DMA_LEN_BITS-1:0]  len_m1;

  assign len_m1 = eng_req.len - 1'b1;

  // Only takes a request when fully idle
  assign eng_ready = (state == ST_IDLE);

  // Bus strobe only while waiting for ack
  assign wb_cyc = (state == ST_BUS);
  assign wb_stb = (state == ST_BUS);
  assign wb_we  = 1'b0;
  assign wb_adr = addr_r;
  // Whole words only
  assign wb_sel = '1;

  // Beat register drives the router
  assign beat_valid = (state == ST_BEAT);
  assign beat_data  = data_r;
  assign beat_last  = last_r;

  // --------------------
  // Control
  // --------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state     <= ST_IDLE;
      remaining <= '0;
      last_r    <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (eng_valid) begin
            remaining <= len_m1[`DMA_LEN_BITS-1:BEAT_LOG_BITS];
            state     <= ST_BUS;
          end
        end
        ST_BUS: begin
          // One word per ack
          if (wb_ack) begin
            last_r <= (remaining == '0);
            state  <= ST_BEAT;
          end
        end
        ST_BEAT: begin
          // Next word waits for the beat to leave, stb low meanwhile
          if (beat_ready) begin
            if (last_r) begin
              state <= ST_IDLE;
            end else begin
              remaining <= remaining - 1'b1;
              state     <= ST_BUS;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // --------------------
  // Datapath
  // --------------------
  always_ff @(posedge aclk) begin
    if (state == ST_IDLE && eng_valid) begin
      addr_r <= eng_req.addr;
    end else if (state == ST_BEAT && beat_ready) begin
      addr_r <= addr_r + `DMA_ADDR_BITS'(WORD_BYTES);
    end
    if (state == ST_BUS && wb_ack) begin
      data_r <= wb_dat_i;
    end
  end

endmodule

/* verilog/dma_data_router.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_data_router import dma_pkg::*; (
  input  logic                       aclk,
  input  logic                       aresetn,

  // Routing queue head
  input  logic                       route_valid,
  output logic                       route_ready,
  input  route_entry_t               route_data,

  // Completion queue head
  input  logic                       cmpl_valid,
  output logic                       cmpl_ready,
  input  done_entry_t                cmpl_data,

  // Beats from the engine
  input  logic                       beat_valid,
  output logic                       beat_ready,
  input  logic [`DMA_DATA_BITS-1:0]  beat_data,
  input  logic                       beat_last,

  // Per region read data
  output logic [`DMA_N_REGIONS-1:0]  rd_valid,
  input  logic [`DMA_N_REGIONS-1:0]  rd_ready,
  output logic [`DMA_DATA_BITS-1:0]  rd_data [`DMA_N_REGIONS],
  output logic [`DMA_N_REGIONS-1:0]  rd_last,

  // Per region completion
  output logic [`DMA_N_REGIONS-1:0]  done,
  output logic [`DMA_PID_BITS-1:0]   done_pid [`DMA_N_REGIONS]
);

  logic [BLEN_BITS-1:0] beat_cnt;
  logic                 take;
  logic                 beat_end;

  // Owner taken from the head routing entry
  assign beat_ready = route_valid && rd_ready[route_data.region];
  assign take       = beat_valid && beat_ready;

  // Either side ending closes the entry, keeps router and engine in step
  assign beat_end = beat_last || (beat_cnt == route_data.beats_m1);

  always_comb begin
    rd_valid = '0;
    rd_last  = '0;
    rd_valid[route_data.region] = beat_valid && route_valid;
    rd_last[route_data.region]  = beat_end;
  end

  // Data fans out, valid selects the owner
  always_comb begin
    for (int i = 0; i < `DMA_N_REGIONS; i++) begin
      rd_data[i] = beat_data;
    end
  end

  assign route_ready = take && beat_end;
  assign cmpl_ready  = take && beat_end && route_data.ctl && cmpl_valid;

  // --------------------
  // Beat count
  // --------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      beat_cnt <= '0;
    end else if (take) begin
      beat_cnt <= beat_end ? '0 : beat_cnt + 1'b1;
    end
  end

  // --------------------
  // Completion pulse
  // --------------------
  // One cycle after the final beat
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      done <= '0;
    end else begin
      done <= '0;
      if (cmpl_ready) begin
        done[cmpl_data.region] <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (cmpl_ready) begin
      done_pid[cmpl_data.region] <= cmpl_data.pid;
    end
  end

endmodule

/* verilog/dma_top.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_top import dma_pkg::*; (
  input  logic                         aclk,
  input  logic                         aresetn,
  // Region requests
  input  logic [`DMA_N_REGIONS-1:0]    req_valid,
  output logic [`DMA_N_REGIONS-1:0]    req_ready,
  input  logic [`DMA_ADDR_BITS-1:0]    req_addr [`DMA_N_REGIONS],
  input  logic [`DMA_LEN_BITS-1:0]     req_len [`DMA_N_REGIONS],
  input  logic [`DMA_N_REGIONS-1:0]    req_ctl,
  input  logic [`DMA_PID_BITS-1:0]     req_pid [`DMA_N_REGIONS],
  // Region read data and completion
  output logic [`DMA_N_REGIONS-1:0]    rd_valid,
  input  logic [`DMA_N_REGIONS-1:0]    rd_ready,
  output logic [`DMA_DATA_BITS-1:0]    rd_data [`DMA_N_REGIONS],
  output logic [`DMA_N_REGIONS-1:0]    rd_last,
  output logic [`DMA_N_REGIONS-1:0]    done,
  output logic [`DMA_PID_BITS-1:0]     done_pid [`DMA_N_REGIONS],
  // Wishbone classic master
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic                         wb_we,
  output logic [`DMA_ADDR_BITS-1:0]    wb_adr,
  output logic [`DMA_DATA_BITS/8-1:0]  wb_sel,
  input  logic [`DMA_DATA_BITS-1:0]    wb_dat_i,
  input  logic                         wb_ack
);

  logic         eng_valid, eng_ready;
  dma_req_t     eng_req;
  logic         route_push_valid, route_push_ready, route_valid, route_ready;
  route_entry_t route_push_data, route_data;
  logic         done_push_valid, done_push_ready, cmpl_valid, cmpl_ready;
  done_entry_t  done_push_data, cmpl_data;
  logic         beat_valid, beat_ready, beat_last;
  logic [`DMA_DATA_BITS-1:0] beat_data;

  dma_rr_arbiter u_arbiter (.*);

  // Routing entries, one per accepted request
  seq_queue #(.DEPTH(`DMA_N_OUTSTANDING), .entry_t(route_entry_t)) u_route_q (
    .aclk(aclk), .aresetn(aresetn),
    .in_valid(route_push_valid), .in_ready(route_push_ready), .in_data(route_push_data),
    .out_valid(route_valid), .out_ready(route_ready), .out_data(route_data)
  );

  // Completion entries, flagged requests only
  seq_queue #(.DEPTH(`DMA_N_OUTSTANDING), .entry_t(done_entry_t)) u_done_q (
    .aclk(aclk), .aresetn(aresetn),
    .in_valid(done_push_valid), .in_ready(done_push_ready), .in_data(done_push_data),
    .out_valid(cmpl_valid), .out_ready(cmpl_ready), .out_data(cmpl_data)
  );

  dma_read_engine u_engine (.*);

  dma_data_router u_router (.*);

endmodule

/* dv/dma_assertions.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_assertions (
  input logic                      aclk,
  input logic                      aresetn,
  input logic                      wb_cyc,
  input logic                      wb_stb,
  input logic [`DMA_ADDR_BITS-1:0] wb_adr,
  input logic                      wb_ack,
  input logic                      beat_valid,
  input logic                      beat_ready,
  input logic [`DMA_DATA_BITS-1:0] beat_data,
  input logic                      beat_last
);

  // --------------------
  // Wishbone classic
  // --------------------
  // Cycle, strobe and address held until ack
  a_stb_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    wb_stb && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr))
    else $error("wb_cyc, wb_stb or wb_adr changed before ack");

  // One idle cycle between words
  a_stb_gap: assert property (@(posedge aclk) disable iff (!aresetn)
    wb_stb && wb_ack |=> !wb_stb) else $error("no strobe gap after ack");

  // --------------------
  // Beat handshake
  // --------------------
  a_beat_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    beat_valid && !beat_ready |=> beat_valid && $stable(beat_data) && $stable(beat_last))
    else $error("beat dropped or changed while stalled");

endmodule

/* dv/dma_tb.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_tb;

  localparam int N       = `DMA_N_REGIONS;
  localparam int MAX_VEC = 64;

  logic                        aclk;
  logic                        aresetn;
  logic [N-1:0]                req_valid;
  logic [N-1:0]                req_ready;
  logic [`DMA_ADDR_BITS-1:0]   req_addr [N];
  logic [`DMA_LEN_BITS-1:0]    req_len [N];
  logic [N-1:0]                req_ctl;
  logic [`DMA_PID_BITS-1:0]    req_pid [N];
  logic [N-1:0]                rd_valid;
  logic [N-1:0]                rd_ready;
  logic [`DMA_DATA_BITS-1:0]   rd_data [N];
  logic [N-1:0]                rd_last;
  logic [N-1:0]                done;
  logic [`DMA_PID_BITS-1:0]    done_pid [N];
  logic                        wb_cyc;
  logic                        wb_stb;
  logic                        wb_we;
  logic [`DMA_ADDR_BITS-1:0]   wb_adr;
  logic [`DMA_DATA_BITS/8-1:0] wb_sel;
  logic [`DMA_DATA_BITS-1:0]   wb_dat_i;
  logic                        wb_ack;

  // Vector word holds test, region, address, length, completion and pid
  logic [67:0] vec [MAX_VEC];
  int          nvec;
  integer      seed;
  int          ack_wait;
  int          err_count;
  int          test_err;
  int          fail_tests;
  bit          stall_en;

  // Scoreboard state per region
  int          pend [N][$];
  logic [32:0] exp_beat [N][$];
  int          exp_done [N][$];
  int          done_order [$];
  int          acc_count [N];
  int          taken_count [N];
  logic [N-1:0] seen_grant [N];

  dma_top uut (.*);

  bind dma_read_engine dma_assertions u_wb_checks (.*);

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  task automatic note_value_error(input string msg);
    $display("[FAIL] %0t %s", $time, msg);
    err_count++;
    test_err++;
  endtask

  task automatic note_error(input string msg);
    $display("error: %s", msg);
    err_count++;
    test_err++;
  endtask

  function automatic int beats_of(input logic [`DMA_LEN_BITS-1:0] len);
    return int'((len - 1'b1) >> 2) + 1;
  endfunction

  function automatic bit work_left();
    for (int r = 0; r < N; r++) begin
      if (pend[r].size() > 0 || exp_beat[r].size() > 0 || exp_done[r].size() > 0) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // --------------------
  // Region drivers
  // --------------------
  always @(negedge aclk) begin : drive_regions
    int idx;
    if (aresetn) begin
      for (int r = 0; r < N; r++) begin
        // Drop a request accepted at the last edge
        if (acc_count[r] != taken_count[r]) begin
          taken_count[r]++;
          idx = pend[r].pop_front();
          req_valid[r] = 1'b0;
        end
        if (!req_valid[r] && pend[r].size() > 0) begin
          idx          = pend[r][0];
          req_valid[r] = 1'b1;
          req_addr[r]  = vec[idx][55:24];
          req_len[r]   = vec[idx][23:12];
          req_ctl[r]   = vec[idx][8];
          req_pid[r]   = vec[idx][5:0];
        end
        rd_ready[r] = stall_en ? 1'($random(seed)) : 1'b1;
      end
    end
  end

  // Memory model acks after 0 to 3 wait cycles
  always @(negedge aclk) begin
    if (!aresetn || wb_ack) begin
      wb_ack   = 1'b0;
      ack_wait = -1;
    end else if (wb_cyc && wb_stb) begin
      if (ack_wait < 0) begin
        ack_wait = int'($unsigned($random(seed)) % 32'd4);
      end
      if (ack_wait == 0) begin
        // Engine reads whole words only
        assert (!wb_we && wb_sel == '1) else
          note_value_error($sformatf("bus cycle at %h we %b sel %b, expected word read",
                                     wb_adr, wb_we, wb_sel));
        wb_ack   = 1'b1;
        wb_dat_i = ~(wb_adr >> 2);
        ack_wait = -1;
      end else begin
        ack_wait--;
      end
    end
  end

  // --------------------
  // Monitor and scoreboard
  // --------------------
  always @(posedge aclk) begin : monitor
    logic [32:0] exp;
    int          pid;
    if (aresetn) begin
      for (int r = 0; r < N; r++) begin
        if (req_valid[r] && req_ready[r]) begin
          acc_count[r]++;
          if (req_ctl[r]) begin
            done_order.push_back(r * 64 + int'(req_pid[r]));
          end
          // Nobody served twice while another waits
          for (int q = 0; q < N; q++) begin
            if (q != r && req_valid[q]) begin
              assert (!seen_grant[q][r]) else
                note_error($sformatf("region %0d served twice while region %0d waited",
                                     r, q));
              seen_grant[q][r] = 1'b1;
            end else if (q != r) begin
              seen_grant[q] = '0;
            end
          end
          seen_grant[r] = '0;
        end
        if (rd_valid[r] && rd_ready[r]) begin
          assert (exp_beat[r].size() > 0) else
            note_error($sformatf("region %0d received a beat it never asked for", r));
          if (exp_beat[r].size() > 0) begin
            exp = exp_beat[r].pop_front();
            assert (rd_data[r] == exp[31:0] && rd_last[r] == exp[32]) else
              note_value_error($sformatf("region %0d beat %h last %b, expected %h last %b",
                                         r, rd_data[r], rd_last[r], exp[31:0], exp[32]));
          end
        end
        if (done[r]) begin
          assert (exp_done[r].size() > 0) else
            note_error($sformatf("region %0d signalled done with no completion asked", r));
          if (exp_done[r].size() > 0) begin
            pid = exp_done[r].pop_front();
            assert (int'(done_pid[r]) == pid) else
              note_value_error($sformatf("region %0d done pid %0d, expected %0d",
                                         r, done_pid[r], pid));
            assert (done_order.size() > 0 && done_order[0] == r * 64 + pid) else
              note_value_error($sformatf("region %0d done out of acceptance order", r));
            if (done_order.size() > 0) begin
              void'(done_order.pop_front());
            end
          end
        end
      end
    end
  end

  // Load one test's requests and wait for all its responses
  task automatic run_test(input int t);
    int          r;
    int          beats;
    logic [31:0] addr;
    test_err = 0;
    stall_en = (t == 4);
    for (int i = 0; i < nvec; i++) begin
      if (int'(vec[i][67:60]) == t) begin
        r     = int'(vec[i][57:56]);
        beats = beats_of(vec[i][23:12]);
        pend[r].push_back(i);
        for (int k = 0; k < beats; k++) begin
          addr = vec[i][55:24] + 32'(4 * k);
          exp_beat[r].push_back({k == beats - 1, ~(addr >> 2)});
        end
        if (vec[i][8]) begin
          exp_done[r].push_back(int'(vec[i][5:0]));
        end
      end
    end
    while (work_left()) begin
      @(posedge aclk);
    end
    // Room for a stray done
    repeat (4) @(posedge aclk);
    if (test_err == 0) begin
      $display("test %0d: ok", t);
    end else begin
      $display("test %0d: %0d errors", t, test_err);
      fail_tests++;
    end
  endtask

  initial begin
    int last_test;
    int total_beats;
    int ntests;
    aresetn   = 1'b0;
    req_valid = '0;
    req_ctl   = '0;
    rd_ready  = '0;
    wb_ack    = 1'b0;
    wb_dat_i  = '0;
    seed      = 93651;
    ack_wait  = -1;
    err_count = 0;
    test_err  = 0;
    fail_tests = 0;
    stall_en  = 1'b0;
    total_beats = 0;
    ntests    = 0;
    for (int r = 0; r < N; r++) begin
      req_addr[r]    = '0;
      req_len[r]     = '0;
      req_pid[r]     = '0;
      acc_count[r]   = 0;
      taken_count[r] = 0;
      seen_grant[r]  = '0;
    end
    // Test field ff marks unused slots
    for (int i = 0; i < MAX_VEC; i++) begin
      vec[i] = {8'hff, 60'(i)};
    end
    $readmemh("dv/dma_vectors.txt", vec);
    nvec = 0;
    while (nvec < MAX_VEC && vec[nvec][67:60] != 8'hff) begin
      total_beats += beats_of(vec[nvec][23:12]);
      nvec++;
    end

    // Watchdog allows eight cycles per beat plus margin
    fork
      begin
        #(total_beats * 8 * 10 + 2000);
        $display("run stopped by watchdog, responses still missing at %0t", $time);
        $display("tests failed");
        $finish;
      end
    join_none

    repeat (4) @(posedge aclk);
    @(negedge aclk);
    test_err = 0;
    assert (req_ready == '0 && rd_valid == '0 && done == '0 && !wb_cyc && !wb_stb) else
      note_value_error("outputs not idle during reset");
    $display("test 0 (reset state): %s", (test_err == 0) ? "ok" : "errors");
    if (test_err != 0) begin
      fail_tests++;
    end
    aresetn = 1'b1;

    last_test = -1;
    for (int i = 0; i < nvec; i++) begin
      if (int'(vec[i][67:60]) != last_test) begin
        last_test = int'(vec[i][67:60]);
        ntests++;
        run_test(last_test);
      end
    end

    $display("summary: %0d tests, %0d failed, %0d errors", ntests + 1, fail_tests, err_count);
    if (err_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+include
verilog/dma_pkg.sv
verilog/seq_queue.sv
verilog/dma_rr_arbiter.sv
verilog/dma_read_engine.sv
verilog/dma_data_router.sv
verilog/dma_top.sv
dv/dma_assertions.sv
dv/dma_tb.sv

/* Makefile */
# Verilator simulation of the shared read-DMA subsystem

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= dma_tb
FILELIST  ?= build.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/dma_vectors.txt */
// test(2) region(1) byte address(8) byte length(3) completion(1) pid(2), hex
// lengths that are not whole words round up to the next word
01_0_00001000_010_0_00
02_1_00002000_00a_1_05
02_2_00003000_008_0_00
02_3_00004000_001_1_09
03_0_00005000_008_1_10
03_1_00005100_008_1_11
03_2_00005200_008_1_12
03_3_00005300_008_1_13
03_0_00005400_004_0_00
03_1_00005500_004_0_00
03_2_00005600_004_0_00
03_3_00005700_004_0_00
04_1_00006000_020_0_00
04_3_00007000_018_1_20
04_1_00006100_00c_1_21
04_3_00007100_010_0_00
05_2_00008000_004_1_30
05_2_00008010_004_1_31
05_2_00008020_004_1_32
05_2_00008030_004_1_33
05_2_00008040_004_1_34
05_2_00008050_004_1_35
05_2_00008060_004_1_36
05_2_00008070_004_1_37
05_2_00008080_004_1_38
05_2_00008090_004_1_39
